// File: design/synth_pkg.sv
package synth_pkg;

    // Voice and sample sizes
    localparam int N_OSC = 4;
    localparam int OSC_IDX_W = $clog2(N_OSC);
    localparam int PHASE_W = 24;          // Phase accumulator and freq word
    localparam int SAMPLE_W = 16;
    localparam int AMP_W = 15;            // Unsigned voice amplitude
    localparam int VOL_W = 8;             // Volume is vol/256
    localparam int MIX_SUM_W = SAMPLE_W + OSC_IDX_W;
    localparam int MIX_PROD_W = MIX_SUM_W + VOL_W + 1;

    // DAC serial timing
    localparam int BCLK_HALF = 2;         // sys_clk cycles per bclk half
    localparam int DIV_W = $clog2(BCLK_HALF);
    localparam int FRAME_BITS = 2 * SAMPLE_W;
    localparam int FRAME_CNT_W = $clog2(FRAME_BITS);

    // SPI frame is address byte plus 24 data bits
    localparam int SPI_FRAME_BITS = 32;
    localparam int SPI_CNT_W = $clog2(SPI_FRAME_BITS) + 1;   // Room to see overlong frames

    // Register map
    localparam logic [7:0] ADDR_FREQ0 = 8'd0;
    localparam logic [7:0] ADDR_CTRL0 = 8'd4;
    localparam logic [7:0] ADDR_VOLUME = 8'd8;

    typedef enum logic {SHAPE_SQUARE, SHAPE_SAW} shape_e;

    typedef struct packed {
        logic             enable;
        shape_e           shape;
        logic [6:0]       reserved;
        logic [AMP_W-1:0] amp;
    } ctrl_word_t;

    // One SPI data word, read as freq or as ctrl depending on address
    typedef union packed {
        logic [PHASE_W-1:0] freq;
        ctrl_word_t         ctrl;
    } cfg_word_u;

    typedef struct packed {
        logic               enable;
        shape_e             shape;
        logic [AMP_W-1:0]   amp;
        logic [PHASE_W-1:0] freq;
    } voice_cfg_t;

    typedef voice_cfg_t [N_OSC-1:0] voice_cfg_arr_t;

    typedef struct packed {
        logic [7:0] addr;
        cfg_word_u  data;
    } spi_wr_t;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
    localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

endpackage

// File: design/spi_cfg_rx.sv
module spi_cfg_rx import synth_pkg::*; (
    input  logic    i_sys_clk,
    input  logic    i_rst_n,
    input  logic    i_spi_clk,
    input  logic    i_spi_mosi,
    input  logic    i_spi_csn,
    output logic    o_wr_stb,
    output spi_wr_t o_wr
);

    logic [2:0]                clk_sync;     // Two sync stages plus edge history
    logic [2:0]                csn_sync;
    logic [1:0]                mosi_sync;
    logic                      clk_rise;
    logic                      csn_rise;
    logic [SPI_FRAME_BITS-1:0] shift_q;
    logic [SPI_CNT_W-1:0]      bit_cnt;

    assign clk_rise = clk_sync[1] & ~clk_sync[2];
    assign csn_rise = csn_sync[1] & ~csn_sync[2];

    // Pin synchronizers
    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            clk_sync  <= '0;
            csn_sync  <= '1;     // Idle deselected
            mosi_sync <= '0;
        end else begin
            clk_sync  <= {clk_sync[1:0], i_spi_clk};
            csn_sync  <= {csn_sync[1:0], i_spi_csn};
            mosi_sync <= {mosi_sync[0], i_spi_mosi};
        end
    end

    // Bit counter and strobe
    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bit_cnt  <= '0;
            o_wr_stb <= 1'b0;
        end else begin
            o_wr_stb <= 1'b0;
            if (csn_rise) begin
                o_wr_stb <= (bit_cnt == SPI_CNT_W'(SPI_FRAME_BITS));  // Full frames only
                bit_cnt  <= '0;
            end else if (!csn_sync[1] && clk_rise && bit_cnt != '1) begin
                bit_cnt <= bit_cnt + 1'b1;   // Saturates so long frames never match
            end
        end
    end

    // MSB first shift, frame captured at deselect
    always_ff @(posedge i_sys_clk) begin
        if (!csn_sync[1] && clk_rise) begin
            shift_q <= {shift_q[SPI_FRAME_BITS-2:0], mosi_sync[1]};
        end
        if (csn_rise) begin
            o_wr <= spi_wr_t'(shift_q);
        end
    end

    // Strobe is a single-cycle pulse per frame
    a_stb_single: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
        o_wr_stb |=> !o_wr_stb);

endmodule

// File: design/synth_regs.sv
module synth_regs import synth_pkg::*; (
    input  logic           i_sys_clk,
    input  logic           i_rst_n,
    input  logic           i_wr_stb,
    input  spi_wr_t        i_wr,
    output voice_cfg_arr_t o_voices,
    output logic [VOL_W-1:0] o_volume
);

    logic [7:0]           freq_off;
    logic [7:0]           ctrl_off;
    logic                 hit_freq;
    logic                 hit_ctrl;
    logic                 hit_vol;
    logic [OSC_IDX_W-1:0] voice_idx;

    // Address decode
    assign freq_off = i_wr.addr - ADDR_FREQ0;
    assign ctrl_off = i_wr.addr - ADDR_CTRL0;
    assign hit_freq = (freq_off < 8'(N_OSC));
    assign hit_ctrl = (ctrl_off < 8'(N_OSC));
    assign hit_vol  = (i_wr.addr == ADDR_VOLUME);
    assign voice_idx = i_wr.addr[OSC_IDX_W-1:0];   // Both bases are multiples of N_OSC

    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_voices <= '0;      // All voices off with zero freq and amp
            o_volume <= '0;
        end else if (i_wr_stb) begin
            if (hit_freq) begin
                o_voices[voice_idx].freq <= i_wr.data.freq;   // Raw increment
            end else if (hit_ctrl) begin
                // Control view of the same word
                o_voices[voice_idx].enable <= i_wr.data.ctrl.enable;
                o_voices[voice_idx].shape  <= i_wr.data.ctrl.shape;
                o_voices[voice_idx].amp    <= i_wr.data.ctrl.amp;
            end else if (hit_vol) begin
                o_volume <= i_wr.data.freq[VOL_W-1:0];        // Low byte only
            end
            // Other addresses dropped
        end
    end

    // Volume writes never disturb voice settings
    a_vol_keeps_voices: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
        (i_wr_stb && i_wr.addr == ADDR_VOLUME) |=> $stable(o_voices));

endmodule

// File: design/oscillator_bank.sv
module oscillator_bank import synth_pkg::*; (
    input  logic                  i_sys_clk,
    input  logic                  i_rst_n,
    input  logic                  i_sample_stb,
    input  voice_cfg_arr_t        i_voices,
    output sample_t [N_OSC-1:0]   o_voice_out
);

    for (genvar v = 0; v < N_OSC; v++) begin : g_voice
        logic [PHASE_W-1:0]            phase_q;
        logic [PHASE_W-1:0]            phase_nxt;
        sample_t                       amp_s;
        sample_t                       saw_top;
        logic signed [2*SAMPLE_W-1:0]  saw_prod;
        sample_t                       wave;

        assign phase_nxt = phase_q + i_voices[v].freq;
        assign amp_s     = sample_t'({1'b0, i_voices[v].amp});   // Always positive
        assign saw_top   = sample_t'(phase_nxt[PHASE_W-1 -: SAMPLE_W]);
        assign saw_prod  = (saw_top * amp_s) >>> AMP_W;

        // Shape from the updated phase
        always_comb begin
            if (i_voices[v].shape == SHAPE_SAW) begin
                wave = saw_prod[SAMPLE_W-1:0];   // Fits, |top*amp| < 2^30
            end else if (phase_nxt[PHASE_W-1]) begin
                wave = -amp_s;                   // Second half cycle
            end else begin
                wave = amp_s;
            end
        end

        always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                phase_q        <= '0;
                o_voice_out[v] <= '0;
            end else if (i_sample_stb) begin
                if (i_voices[v].enable) begin
                    phase_q        <= phase_nxt;
                    o_voice_out[v] <= wave;
                end else begin
                    phase_q        <= '0;        // Restart from zero when re-enabled
                    o_voice_out[v] <= '0;
                end
            end
        end
    end

endmodule

// File: design/voice_mixer.sv
module voice_mixer import synth_pkg::*; (
    input  logic                i_sys_clk,
    input  logic                i_rst_n,
    input  logic                i_sample_stb,
    input  sample_t [N_OSC-1:0] i_voice_out,
    input  logic [VOL_W-1:0]    i_volume,
    output sample_t             o_mix
);

    logic                           stb_d;        // Voices settled this cycle
    logic signed [MIX_SUM_W-1:0]    sum;
    logic signed [MIX_PROD_W-1:0]   prod;
    logic signed [MIX_PROD_W-1:0]   scaled;
    sample_t                        sat;

    // Full width sum, no overflow possible
    always_comb begin
        sum = '0;
        for (int i = 0; i < N_OSC; i++) begin
            sum = sum + MIX_SUM_W'(i_voice_out[i]);
        end
    end

    assign prod   = sum * $signed({1'b0, i_volume});   // Volume as positive factor
    assign scaled = prod >>> VOL_W;

    // Clip to sample range
    always_comb begin
        if (scaled > SAMPLE_MAX)      sat = SAMPLE_MAX;
        else if (scaled < SAMPLE_MIN) sat = SAMPLE_MIN;
        else                          sat = scaled[SAMPLE_W-1:0];
    end

    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            stb_d <= 1'b0;
            o_mix <= '0;
        end else begin
            stb_d <= i_sample_stb;
            if (stb_d) o_mix <= sat;
        end
    end

    // Output moves only right after a strobe has stepped the oscillators
    a_mix_on_stb: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
        $changed(o_mix) |-> $past(i_sample_stb, 2));

endmodule

// File: design/dac_i2s_tx.sv
module dac_i2s_tx import synth_pkg::*; (
    input  logic    i_sys_clk,
    input  logic    i_rst_n,
    input  sample_t i_mix,
    output logic    o_sample_stb,
    output logic    o_dac_bclk,
    output logic    o_dac_lrclk,
    output logic    o_dac_sd
);

    logic [DIV_W-1:0]       div_cnt;
    logic                   tick;         // Bit clock toggles this cycle
    logic                   bclk_fall;
    logic [FRAME_CNT_W-1:0] bit_cnt;      // Position of the bit now on the line
    logic [FRAME_CNT_W-1:0] bit_nxt;
    logic [FRAME_BITS-1:0]  frame_sr;     // Left word then right word

    assign tick      = (div_cnt == DIV_W'(BCLK_HALF - 1));
    assign bclk_fall = tick & o_dac_bclk;
    assign bit_nxt   = bit_cnt + 1'b1;    // Wraps at frame end
    assign o_dac_sd  = frame_sr[FRAME_BITS-1];

    // Bit clock divider
    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            div_cnt    <= '0;
            o_dac_bclk <= 1'b0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick) o_dac_bclk <= ~o_dac_bclk;
        end
    end

    // Frame position, LR select and shifter
    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bit_cnt     <= '1;        // First fall starts a frame
            o_dac_lrclk <= 1'b0;
            frame_sr    <= '0;
        end else if (bclk_fall) begin
            bit_cnt     <= bit_nxt;
            o_dac_lrclk <= bit_nxt[FRAME_CNT_W-1];   // High for second word
            if (bit_nxt == '0) begin
                frame_sr <= {i_mix, i_mix};          // Same sample on both channels
            end else begin
                frame_sr <= frame_sr << 1;
            end
        end
    end

    // Strobe at the fall before the last bit, 4 cycles ahead of the load
    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_sample_stb <= 1'b0;
        end else begin
            o_sample_stb <= bclk_fall && (bit_cnt == FRAME_CNT_W'(FRAME_BITS - 2));
        end
    end

    // Receiver samples on the rise, so outputs may only move on the fall
    a_change_on_fall: assert property (@(posedge i_sys_clk) disable iff (!i_rst_n)
        ($changed(o_dac_lrclk) || $changed(o_dac_sd)) |-> $fell(o_dac_bclk));

endmodule

// File: design/synth_top.sv
module synth_top import synth_pkg::*; (
    input  logic i_sys_clk,
    input  logic i_rst_n,
    input  logic i_spi_clk,
    input  logic i_spi_mosi,
    input  logic i_spi_csn,
    output logic o_dac_bclk,
    output logic o_dac_lrclk,
    output logic o_dac_sd
);

    logic                wr_stb;
    spi_wr_t             wr;
    voice_cfg_arr_t      voices;
    logic [VOL_W-1:0]    volume;
    logic                sample_stb;     // Once per DAC frame
    sample_t [N_OSC-1:0] voice_out;
    sample_t             mix;

    spi_cfg_rx u_spi_cfg_rx (
        .i_sys_clk  (i_sys_clk),
        .i_rst_n    (i_rst_n),
        .i_spi_clk  (i_spi_clk),
        .i_spi_mosi (i_spi_mosi),
        .i_spi_csn  (i_spi_csn),
        .o_wr_stb   (wr_stb),
        .o_wr       (wr)
    );

    synth_regs u_synth_regs (
        .i_sys_clk (i_sys_clk),
        .i_rst_n   (i_rst_n),
        .i_wr_stb  (wr_stb),
        .i_wr      (wr),
        .o_voices  (voices),
        .o_volume  (volume)
    );

    oscillator_bank u_oscillator_bank (
        .i_sys_clk    (i_sys_clk),
        .i_rst_n      (i_rst_n),
        .i_sample_stb (sample_stb),
        .i_voices     (voices),
        .o_voice_out  (voice_out)
    );

    voice_mixer u_voice_mixer (
        .i_sys_clk    (i_sys_clk),
        .i_rst_n      (i_rst_n),
        .i_sample_stb (sample_stb),
        .i_voice_out  (voice_out),
        .i_volume     (volume),
        .o_mix        (mix)
    );

    dac_i2s_tx u_dac_i2s_tx (
        .i_sys_clk    (i_sys_clk),
        .i_rst_n      (i_rst_n),
        .i_mix        (mix),
        .o_sample_stb (sample_stb),
        .o_dac_bclk   (o_dac_bclk),
        .o_dac_lrclk  (o_dac_lrclk),
        .o_dac_sd     (o_dac_sd)
    );

endmodule

// File: verif/tb_synth.sv
module tb_synth import synth_pkg::*; ();

    typedef enum {CHK_OFF, CHK_ZERO, CHK_SET, CHK_SAW} chk_mode_e;

    localparam int SPI_HALF = 8;                    // sys_clk cycles per SPI clock half
    localparam int N_WRITES = 14;
    localparam int N_FRAMES = 66 + N_WRITES * 5;    // Waited frames plus frames spent in writes
    localparam longint WATCHDOG_T = longint'(N_FRAMES * 128 + N_WRITES * 400) * 40 * 12 / 10;
    localparam int SAW_VOICE = 1;
    localparam logic [PHASE_W-1:0] SAW_FREQ = 24'h0C0000;

    logic sys_clk = 1'b0;
    logic rst_n;
    logic spi_clk;
    logic spi_mosi;
    logic spi_csn;
    logic dac_bclk;
    logic dac_lrclk;
    logic dac_sd;

    voice_cfg_arr_t                model_voices;    // Expected register contents
    logic [VOL_W-1:0]              model_vol;
    chk_mode_e                     mode = CHK_OFF;
    sample_t                       exp_set [4];     // Allowed words in CHK_SET
    logic [3:0]                    seen;
    logic                          saw_started;
    logic [PHASE_W-1:0]            saw_phase;
    logic [N_OSC-1:0][PHASE_W-1:0] ref_phase;
    int                            value_errs = 0;
    int                            other_errs = 0;

    // I2S receiver state
    logic    rx_lr_q = 1'b0;
    logic    rx_left_ok = 1'b0;
    int      rx_cnt = 0;
    sample_t rx_shift = '0;
    sample_t rx_left;
    sample_t left_word;
    sample_t right_word;
    event    frame_ev;

    always #20 sys_clk = ~sys_clk;

    synth_top u_dut (
        .i_sys_clk   (sys_clk),
        .i_rst_n     (rst_n),
        .i_spi_clk   (spi_clk),
        .i_spi_mosi  (spi_mosi),
        .i_spi_csn   (spi_csn),
        .o_dac_bclk  (dac_bclk),
        .o_dac_lrclk (dac_lrclk),
        .o_dac_sd    (dac_sd)
    );

    // Expected mix for given settings and phases
    function automatic sample_t mix_ref(input voice_cfg_arr_t voices,
                                        input logic [N_OSC-1:0][PHASE_W-1:0] phase,
                                        input logic [VOL_W-1:0] vol);
        longint sum;
        longint wave;
        longint scaled;
        sum = 0;
        for (int v = 0; v < N_OSC; v++) begin
            if (!voices[v].enable) wave = 0;
            else if (voices[v].shape == SHAPE_SAW)
                wave = (longint'($signed(phase[v][PHASE_W-1 -: SAMPLE_W]))
                        * longint'(voices[v].amp)) >>> AMP_W;
            else if (phase[v][PHASE_W-1]) wave = -longint'(voices[v].amp);   // Low half
            else wave = longint'(voices[v].amp);
            sum += wave;
        end
        scaled = (sum * longint'(vol)) >>> VOL_W;
        if (scaled > longint'(SAMPLE_MAX)) return SAMPLE_MAX;    // Clip
        if (scaled < longint'(SAMPLE_MIN)) return SAMPLE_MIN;
        return sample_t'(scaled);
    endfunction

    function automatic sample_t allowed_match(input sample_t got);
        sample_t pick;
        pick = exp_set[0];               // Reported when nothing matches
        for (int i = 0; i < 4; i++) if (got == exp_set[i]) pick = exp_set[i];
        return pick;
    endfunction

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // Mode 0 with MSB first. A short frame sends only the low nbits
    task automatic spi_send(input spi_wr_t frame, input int nbits);
        logic [SPI_FRAME_BITS-1:0] bits;
        bits = frame;
        spi_csn = 1'b0;
        for (int i = 0; i < nbits; i++) begin
            spi_mosi = bits[nbits-1-i];
            repeat (SPI_HALF) @(negedge sys_clk);
            spi_clk = 1'b1;
            repeat (SPI_HALF) @(negedge sys_clk);
            spi_clk = 1'b0;
        end
        repeat (SPI_HALF) @(negedge sys_clk);
        spi_csn = 1'b1;
        repeat (2 * SPI_HALF) @(negedge sys_clk);   // Strobe and register update land here
    endtask

    task automatic write_reg(input logic [7:0] addr, input cfg_word_u data);
        spi_send({addr, data}, SPI_FRAME_BITS);
        if (addr < 8'd4) model_voices[addr[1:0]].freq = data.freq;
        else if (addr < 8'd8) begin
            model_voices[addr[1:0]].enable = data.ctrl.enable;
            model_voices[addr[1:0]].shape  = data.ctrl.shape;
            model_voices[addr[1:0]].amp    = data.ctrl.amp;
        end else if (addr == ADDR_VOLUME) model_vol = data.freq[VOL_W-1:0];
    endtask

    task automatic write_ctrl(input int idx, input logic en, input shape_e sh,
                              input logic [AMP_W-1:0] amp);
        cfg_word_u w;
        w = '0;
        w.ctrl.enable = en;
        w.ctrl.shape  = sh;
        w.ctrl.amp    = amp;
        write_reg(8'(ADDR_CTRL0 + idx), w);
    endtask

    // Four sign combinations of square voices va and vb
    task automatic arm_set(input int va, input int vb);
        logic [N_OSC-1:0][PHASE_W-1:0] ph;
        for (int c = 0; c < 4; c++) begin
            ph = '0;
            ph[vb][PHASE_W-1] = c[1];
            ph[va][PHASE_W-1] = c[0];
            exp_set[c] = mix_ref(model_voices, ph, model_vol);
        end
        seen = '0;
        mode = CHK_SET;
    endtask

    task automatic wait_frames(input int n);
        repeat (n) @(frame_ev);
        @(negedge sys_clk);              // Step off the compare edge
    endtask

    // Word boundaries come from LR edges and short words are dropped
    always @(posedge dac_bclk) begin
        if (dac_lrclk != rx_lr_q) begin
            if (!rx_lr_q) begin
                rx_left_ok = (rx_cnt == SAMPLE_W);
                rx_left    = rx_shift;
            end else if (rx_left_ok && rx_cnt == SAMPLE_W) begin
                left_word  = rx_left;
                right_word = rx_shift;
                -> frame_ev;
            end
            rx_cnt = 0;
        end
        rx_shift = {rx_shift[SAMPLE_W-2:0], dac_sd};
        rx_cnt++;
        rx_lr_q = dac_lrclk;
    end

    always @(frame_ev) begin
        check_sample("o_dac_sd right word", right_word, left_word);
        case (mode)
            CHK_ZERO: check_sample("o_dac_sd left word", left_word, '0);
            CHK_SET: begin
                check_sample("o_dac_sd left word", left_word, allowed_match(left_word));
                for (int i = 0; i < 4; i++) if (left_word == exp_set[i]) seen[i] = 1'b1;
            end
            CHK_SAW: if (saw_started || left_word != '0) begin
                saw_phase   = saw_started ? saw_phase + SAW_FREQ : SAW_FREQ;
                saw_started = 1'b1;
                ref_phase   = '0;
                ref_phase[SAW_VOICE] = saw_phase;
                check_sample("o_dac_sd left word", left_word,
                             mix_ref(model_voices, ref_phase, model_vol));
            end
            default: ;
        endcase
    end

    initial begin
        #(WATCHDOG_T);
        $display("Timeout: run did not finish within %0d time units", WATCHDOG_T);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(87167));
        rst_n        = 1'b0;
        spi_clk      = 1'b0;
        spi_mosi     = 1'b0;
        spi_csn      = 1'b1;
        model_voices = '0;
        model_vol    = '0;
        saw_started  = 1'b0;
        repeat (6) @(negedge sys_clk);
        check_level("o_dac_bclk", dac_bclk, 1'b0);
        check_level("o_dac_lrclk", dac_lrclk, 1'b0);
        check_level("o_dac_sd", dac_sd, 1'b0);
        repeat (2) @(negedge sys_clk);
        rst_n = 1'b1;
        mode  = CHK_ZERO;                // Silent until configured
        wait_frames(4);

        write_reg(ADDR_FREQ0, 24'h200000);                  // Sign flips every 4 frames
        write_reg(ADDR_VOLUME, 24'($urandom_range(255, 64)));
        mode = CHK_OFF;
        write_ctrl(0, 1'b1, SHAPE_SQUARE, AMP_W'($urandom_range(32767, 4096)));
        wait_frames(3);
        arm_set(0, 0);
        wait_frames(16);
        if (!(seen[0] && seen[1])) begin
            other_errs++;
            $display("Square voice did not show both signs");
        end

        mode = CHK_OFF;
        write_ctrl(0, 1'b0, SHAPE_SQUARE, '0);
        wait_frames(3);
        mode = CHK_ZERO;
        wait_frames(2);
        write_reg(8'(ADDR_FREQ0 + SAW_VOICE), SAW_FREQ);
        mode = CHK_SAW;
        write_ctrl(SAW_VOICE, 1'b1, SHAPE_SAW, AMP_W'($urandom_range(32767, 4096)));
        wait_frames(6);
        write_reg(8'd9, 24'hFFFFFE);    // Unmapped address
        // A short frame lands behind that last zero bit and would decode as a ctrl write
        // that mutes the saw if it were accepted
        spi_send({8'(ADDR_CTRL0 + SAW_VOICE), 24'h000000}, SPI_FRAME_BITS - 1);
        wait_frames(6);
        if (!saw_started) begin
            other_errs++;
            $display("Saw voice never produced a nonzero sample");
        end

        mode = CHK_OFF;
        write_ctrl(SAW_VOICE, 1'b0, SHAPE_SAW, '0);
        write_reg(8'(ADDR_FREQ0 + 2), 24'h155555);
        write_ctrl(2, 1'b1, SHAPE_SQUARE, AMP_W'($urandom_range(32767, 4096)));
        write_ctrl(0, 1'b1, SHAPE_SQUARE, AMP_W'($urandom_range(32767, 4096)));
        wait_frames(3);
        arm_set(0, 2);
        wait_frames(16);
        mode = CHK_OFF;
        write_ctrl(0, 1'b0, SHAPE_SQUARE, '0);
        write_ctrl(2, 1'b0, SHAPE_SQUARE, '0);
        wait_frames(3);                  // Pipeline drains within three frames
        mode = CHK_ZERO;
        wait_frames(4);

        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
design/synth_pkg.sv
design/spi_cfg_rx.sv
design/synth_regs.sv
design/oscillator_bank.sv
design/voice_mixer.sv
design/dac_i2s_tx.sv
design/synth_top.sv
verif/tb_synth.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_synth \
    -f compile.f -o tb_synth_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_synth_sim > sim.log 2>&1 \
    || { cat sim.log; echo "Simulator stopped with an error"; exit 1; }
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
